// File: filelist.f
verilog/io_pkg.sv
verilog/io_bus_if.sv
verilog/io_dcd.sv
verilog/io_reg.sv
verilog/io_uart.sv
verilog/io_top.sv
sim/io_tb_assertions.sv
sim/io_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the console I/O testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --top-module io_tb -f filelist.f -o io_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/io_sim +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "TESTBENCH FAILED" "$LOG"; then
   exit 1
fi
exit 0

// File: sim/io_tb.sv
`default_nettype none

module io_tb;

   logic        sysclk;
   logic        rst;
   logic [4:0]  cs_io;
   logic [7:0]  idb_in;
   logic [15:0] idb_out;
   logic        int_rx_n;
   logic        int_tx_n;
   logic [1:0]  io_led;
   wire         serial;          // txd looped back into rxd
   logic [7:0]  data_bytes [4];  // Random payloads
   logic [2:0]  ctrl_val;
   logic [15:0] rd;
   int          tests;
   int          checks;
   int          errors;

   io_top i_dut (
      .sysclk   (sysclk),
      .rst      (rst),
      .cs_io    (cs_io),
      .idb_in   (idb_in),
      .idb_out  (idb_out),
      .rxd      (serial),
      .txd      (serial),
      .int_rx_n (int_rx_n),
      .int_tx_n (int_tx_n),
      .io_led   (io_led)
   );

   initial begin
      sysclk = 1'b0;
      forever #50 sysclk = ~sysclk;
   end

   initial begin
      // Six slow frames plus slack for the register traffic
      #((6 * 10 * io_pkg::DIV_SLOW + 200) * 100);
      $display("Watchdog expired before the tests finished");
      $display("TESTBENCH FAILED");
      $finish;
   end

   task automatic wait_clocks(input int n);
      repeat (n) @(posedge sysclk);
      #10;
   endtask

   // Field sampled on the first edge, idb_out loaded on the second
   task automatic io_write(input logic [4:0] code, input logic [7:0] data);
      cs_io  = code;
      idb_in = data;
      @(posedge sysclk);
      #10 cs_io = 5'h00;
      @(posedge sysclk);
      #10;
   endtask

   task automatic io_read(input logic [4:0] code, output logic [15:0] value);
      io_write(code, 8'h00);
      value = idb_out;
   endtask

   task automatic check(input string name, input logic [15:0] exp, input logic [15:0] act);
      checks++;
      assert (act === exp) else begin
         $display("Fail %s: expected %h, actual %h", name, exp, act);
         errors++;
      end
   endtask

   task automatic test_done(input string name);
      tests++;
      $display("Test %-10s finished, %0d errors so far", name, errors);
   endtask

   function automatic logic [15:0] status_word(input logic da, input logic tbmt, input logic ovr);
      logic [15:0] w;
      w = 16'h0000;
      w[io_pkg::STAT_DA]   = da;
      w[io_pkg::STAT_TBMT] = tbmt;
      w[io_pkg::STAT_OVR]  = ovr;
      return w;
   endfunction

   // Polls status until every bit in mask is set
   task automatic wait_status(input string name, input logic [15:0] mask);
      logic [15:0] s;
      int          tries;
      s     = 16'h0000;
      tries = 0;
      while ((s & mask) != mask && tries < 10 * io_pkg::DIV_SLOW) begin
         io_read(io_pkg::CODE_RD_STATUS, s);
         tries++;
      end
      if ((s & mask) != mask) begin
         $display("%s: status bits %h never came up", name, mask);
         errors++;
      end
   endtask

   // Sends a byte and samples txd at each mid-bit
   task automatic tx_frame(input string name, input logic [7:0] b, input int div);
      logic [15:0] s;
      int          i;
      io_write(io_pkg::CODE_WR_DATA, b);
      io_read(io_pkg::CODE_RD_STATUS, s);
      check({name, " tbmt busy"}, 16'h0000, 16'(s[io_pkg::STAT_TBMT]));
      wait_clocks(div / 2 - 2);   // Start bit began two reads ago
      check({name, " start"}, 16'h0000, 16'(serial));
      for (i = 0; i < 8; i++) begin
         wait_clocks(div);
         check($sformatf("%s bit%0d", name, i), 16'(b[i]), 16'(serial));
      end
      wait_clocks(div);
      check({name, " stop"}, 16'h0001, 16'(serial));
   endtask

   initial begin
      void'($urandom(32'ha95c));
      tests    = 0;
      checks   = 0;
      errors   = 0;
      rst      = 1'b1;
      cs_io    = 5'h00;
      idb_in   = 8'h00;
      ctrl_val = 3'($urandom);
      foreach (data_bytes[k]) data_bytes[k] = 8'($urandom);
      repeat (2) @(posedge sysclk);
      #10 rst = 1'b0;
      wait_clocks(1);

      check("reset txd", 16'h0001, 16'(serial));
      check("reset int_rx_n", 16'h0001, 16'(int_rx_n));
      check("reset int_tx_n", 16'h0001, 16'(int_tx_n));
      check("reset led", 16'h0002, 16'(io_led));   // Green only
      io_read(io_pkg::CODE_RD_STATUS, rd);
      check("reset status", status_word(1'b0, 1'b1, 1'b0), rd);
      io_read(io_pkg::CODE_RD_CTRL, rd);
      check("reset ctrl", 16'h0000, rd);
      test_done("reset");

      io_write(io_pkg::CODE_WR_CTRL, {5'd0, ctrl_val});
      io_read(io_pkg::CODE_RD_CTRL, rd);
      check("ctrl readback", {13'd0, ctrl_val}, rd);
      io_read(5'h1f, rd);   // Unknown field
      check("ctrl unknown code", {13'd0, ctrl_val}, rd);
      io_write(io_pkg::CODE_WR_CTRL, 8'h00);
      test_done("ctrl");

      tx_frame("tx fast", data_bytes[0], io_pkg::DIV_FAST);
      wait_status("tx fast", status_word(1'b1, 1'b1, 1'b0));
      test_done("transmit");

      io_read(io_pkg::CODE_RD_DATA, rd);
      check("rx data", {8'h00, data_bytes[0]}, rd);
      io_read(io_pkg::CODE_RD_STATUS, rd);
      check("rx status after read", status_word(1'b0, 1'b1, 1'b0), rd);
      test_done("receive");

      // Both enables and the slow divisor
      io_write(io_pkg::CODE_WR_CTRL, 8'h07);
      wait_clocks(1);
      check("irq tx idle", 16'h0000, 16'(int_tx_n));
      check("irq rx idle", 16'h0001, 16'(int_rx_n));
      tx_frame("tx slow", data_bytes[1], io_pkg::DIV_SLOW);
      wait_status("tx slow", status_word(1'b1, 1'b1, 1'b0));
      check("irq rx on da", 16'h0000, 16'(int_rx_n));
      io_read(io_pkg::CODE_RD_DATA, rd);
      check("slow rx data", {8'h00, data_bytes[1]}, rd);
      wait_clocks(1);
      check("irq rx cleared", 16'h0001, 16'(int_rx_n));
      io_write(io_pkg::CODE_WR_CTRL, 8'h00);
      test_done("irq_baud");

      io_write(io_pkg::CODE_WR_DATA, data_bytes[2]);
      wait_status("ovr first", status_word(1'b1, 1'b1, 1'b0));
      io_write(io_pkg::CODE_WR_DATA, data_bytes[3]);
      wait_status("ovr second", status_word(1'b0, 1'b1, 1'b1));
      io_read(io_pkg::CODE_RD_STATUS, rd);
      check("ovr status", status_word(1'b1, 1'b1, 1'b1), rd);
      check("ovr led red", 16'h0001, 16'(io_led));
      io_read(io_pkg::CODE_RD_DATA, rd);
      check("ovr data", {8'h00, data_bytes[3]}, rd);
      io_read(io_pkg::CODE_RD_STATUS, rd);
      check("ovr cleared", status_word(1'b0, 1'b1, 1'b0), rd);
      check("ovr led green", 16'h0002, 16'(io_led));
      test_done("overrun");

      errors = errors + int'(i_dut.i_assert.fail_cnt);
      $display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
      if (errors == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: sim/io_tb_assertions.sv
`default_nettype none

module io_tb_assertions (
   input wire logic              sysclk,
   input wire logic              rst,
   input wire logic [4:0]        cs_io,
   input wire logic [15:0]       idb_out,
   input wire logic              txd,
   input wire logic              int_rx_n,
   input wire logic              int_tx_n,
   input wire io_pkg::tx_state_e tx_state,
   input wire logic              da,       // UART flag
   input wire logic              tbmt,     // UART flag
   input wire logic [2:0]        ctrl      // Control register
);

   int unsigned fail_cnt = 0;
   logic        was_read;
   logic        rx_cond;
   logic        tx_cond;

   assign was_read = (cs_io == io_pkg::CODE_RD_DATA) ||
                     (cs_io == io_pkg::CODE_RD_STATUS) ||
                     (cs_io == io_pkg::CODE_RD_CTRL);

   // Interrupt conditions straight from the flags and enables
   assign rx_cond = da && ctrl[io_pkg::CTRL_RX_IE];
   assign tx_cond = tbmt && ctrl[io_pkg::CTRL_TX_IE];

   // Line idles high between frames
   a_txd_idle: assert property (@(posedge sysclk) disable iff (rst)
      (tx_state == io_pkg::TX_IDLE) |-> txd)
      else begin
         fail_cnt++;
         $error("txd low while the transmitter is idle");
      end

   a_int_rx: assert property (@(posedge sysclk) disable iff (rst)
      int_rx_n == !$past(rx_cond))
      else begin
         fail_cnt++;
         $error("int_rx_n does not follow its condition one cycle late");
      end

   a_int_tx: assert property (@(posedge sysclk) disable iff (rst)
      int_tx_n == !$past(tx_cond))
      else begin
         fail_cnt++;
         $error("int_tx_n does not follow its condition one cycle late");
      end

   // Field sampled two edges before idb_out moves
   a_idb_hold: assert property (@(posedge sysclk) disable iff (rst)
      $changed(idb_out) |-> $past(was_read, 2))
      else begin
         fail_cnt++;
         $error("idb_out changed without a read command");
      end

endmodule

bind io_top io_tb_assertions i_assert (
   .sysclk   (sysclk),
   .rst      (rst),
   .cs_io    (cs_io),
   .idb_out  (idb_out),
   .txd      (txd),
   .int_rx_n (int_rx_n),
   .int_tx_n (int_tx_n),
   .tx_state (i_uart.tx_state),
   .da       (i_uart.da),
   .tbmt     (i_uart.tbmt),
   .ctrl     (i_reg.ctrl)
);

`default_nettype wire

// File: verilog/io_top.sv
`default_nettype none

module io_top (
   input  wire logic        sysclk,    // System clock
   input  wire logic        rst,
   input  wire logic [4:0]  cs_io,     // Microcode I/O field
   input  wire logic [7:0]  idb_in,
   output logic      [15:0] idb_out,
   input  wire logic        rxd,
   output logic             txd,
   output logic             int_rx_n,
   output logic             int_tx_n,
   output logic      [1:0]  io_led     // 0 red, 1 green
);

   logic baud_sel;
   logic data_taken;

   io_bus_if i_bus ();

   // Command decoder and IDB read gather
   io_dcd i_dcd (
      .sysclk  (sysclk),
      .rst     (rst),
      .cs_io   (cs_io),
      .idb_in  (idb_in),
      .idb_out (idb_out),
      .bus     (i_bus.decoder)
   );

   // Control and status, interrupts and LEDs
   io_reg i_reg (
      .sysclk     (sysclk),
      .rst        (rst),
      .bus        (i_bus.unit),
      .baud_sel   (baud_sel),
      .data_taken (data_taken),
      .int_rx_n   (int_rx_n),
      .int_tx_n   (int_tx_n),
      .io_led     (io_led)
   );

   // Console serial port
   io_uart i_uart (
      .sysclk     (sysclk),
      .rst        (rst),
      .bus        (i_bus.unit),
      .baud_sel   (baud_sel),
      .data_taken (data_taken),
      .rxd        (rxd),
      .txd        (txd)
   );

endmodule

`default_nettype wire

// File: verilog/io_uart.sv
`default_nettype none

module io_uart (
   input  wire logic sysclk,
   input  wire logic rst,
   io_bus_if.unit    bus,
   input  wire logic baud_sel,     // 1 selects DIV_SLOW
   input  wire logic data_taken,
   input  wire logic rxd,
   output logic      txd
);

   io_pkg::cnt_t      div_m1;
   io_pkg::cnt_t      div_half;
   io_pkg::tx_state_e tx_state;
   io_pkg::rx_state_e rx_state;
   io_pkg::cnt_t      tx_cnt;
   io_pkg::cnt_t      rx_cnt;
   logic [2:0]        tx_bit;
   logic [2:0]        rx_bit;
   logic [7:0]        tx_shift;
   logic [7:0]        rx_shift;
   logic [7:0]        rx_hold;
   logic              tx_load;
   logic              tx_tick;
   logic              rx_tick;
   logic              rx_sample;
   logic              rx_done;
   logic              rx_meta;
   logic              rx_sync;
   logic              da;
   logic              ovr;
   logic              tbmt;

   assign div_m1 = baud_sel ? io_pkg::cnt_t'(io_pkg::DIV_SLOW - 1)
                            : io_pkg::cnt_t'(io_pkg::DIV_FAST - 1);
   assign div_half = div_m1 >> 1;   // Mid-bit offset

   assign tbmt    = (tx_state == io_pkg::TX_IDLE);
   assign tx_load = tbmt && (bus.cmd == io_pkg::CMD_WR_DATA);   // Busy writes dropped
   assign tx_tick = !tbmt && (tx_cnt >= div_m1);

   // Transmitter, LSB first
   always_ff @(posedge sysclk) begin
      if (rst) begin
         tx_state <= io_pkg::TX_IDLE;
         tx_cnt   <= '0;
         tx_bit   <= 3'd0;
         txd      <= 1'b1;
      end else if (tx_load) begin
         tx_state <= io_pkg::TX_START;
         tx_cnt   <= '0;
         txd      <= 1'b0;   // Start bit
      end else if (!tbmt) begin
         tx_cnt <= tx_tick ? '0 : tx_cnt + 1'b1;
         if (tx_tick) begin
            case (tx_state)
               io_pkg::TX_START: begin
                  tx_state <= io_pkg::TX_DATA;
                  tx_bit   <= 3'd0;
                  txd      <= tx_shift[0];
               end
               io_pkg::TX_DATA: begin
                  if (tx_bit == 3'd7) begin
                     tx_state <= io_pkg::TX_STOP;
                     txd      <= 1'b1;
                  end else begin
                     tx_bit <= tx_bit + 1'b1;
                     txd    <= tx_shift[1];   // Next bit after the shift
                  end
               end
               default: tx_state <= io_pkg::TX_IDLE;   // Stop bit done
            endcase
         end
      end
   end

   always_ff @(posedge sysclk) begin
      if (tx_load) begin
         tx_shift <= bus.wdata;
      end else if (tx_tick && tx_state == io_pkg::TX_DATA) begin
         tx_shift <= tx_shift >> 1;
      end
   end

   // Two-flop synchroniser, idles high
   always_ff @(posedge sysclk) begin
      if (rst) begin
         rx_meta <= 1'b1;
         rx_sync <= 1'b1;
      end else begin
         rx_meta <= rxd;
         rx_sync <= rx_meta;
      end
   end

   assign rx_tick   = (rx_cnt >= div_m1);
   assign rx_sample = (rx_state == io_pkg::RX_DATA) && rx_tick;
   assign rx_done   = (rx_state == io_pkg::RX_STOP) && rx_tick;

   // Receiver, START waits half a bit then samples every full bit
   always_ff @(posedge sysclk) begin
      if (rst) begin
         rx_state <= io_pkg::RX_IDLE;
         rx_cnt   <= '0;
         rx_bit   <= 3'd0;
      end else begin
         case (rx_state)
            io_pkg::RX_IDLE: begin
               rx_cnt <= '0;
               if (!rx_sync) rx_state <= io_pkg::RX_START;
            end
            io_pkg::RX_START: begin
               if (rx_cnt == div_half) begin
                  rx_cnt   <= '0;
                  rx_bit   <= 3'd0;
                  // Glitch shorter than half a bit is dropped
                  rx_state <= rx_sync ? io_pkg::RX_IDLE : io_pkg::RX_DATA;
               end else begin
                  rx_cnt <= rx_cnt + 1'b1;
               end
            end
            io_pkg::RX_DATA: begin
               rx_cnt <= rx_tick ? '0 : rx_cnt + 1'b1;
               if (rx_tick) begin
                  rx_bit <= rx_bit + 1'b1;
                  if (rx_bit == 3'd7) rx_state <= io_pkg::RX_STOP;
               end
            end
            default: begin
               rx_cnt <= rx_tick ? '0 : rx_cnt + 1'b1;
               if (rx_tick) rx_state <= io_pkg::RX_IDLE;
            end
         endcase
      end
   end

   always_ff @(posedge sysclk) begin
      if (rx_sample) rx_shift <= {rx_sync, rx_shift[7:1]};
      if (rx_done)   rx_hold  <= rx_shift;   // New byte always wins
   end

   // Data available and overrun flags
   always_ff @(posedge sysclk) begin
      if (rst) begin
         da  <= 1'b0;
         ovr <= 1'b0;
      end else if (rx_done) begin
         da  <= 1'b1;
         ovr <= da && !data_taken;   // ovr never stands without da
      end else if (data_taken) begin
         da  <= 1'b0;
         ovr <= 1'b0;
      end
   end

   always_comb begin
      bus.status = 3'b000;
      bus.status[io_pkg::STAT_DA]   = da;
      bus.status[io_pkg::STAT_TBMT] = tbmt;
      bus.status[io_pkg::STAT_OVR]  = ovr;
   end

   always_comb begin
      case (bus.cmd)
         io_pkg::CMD_RD_DATA:   bus.rdata_uart = {8'h00, rx_hold};
         io_pkg::CMD_RD_STATUS: bus.rdata_uart = {13'd0, bus.status};
         default:               bus.rdata_uart = 16'h0000;
      endcase
   end

endmodule

`default_nettype wire

// File: verilog/io_reg.sv
`default_nettype none

module io_reg (
   input  wire logic       sysclk,
   input  wire logic       rst,
   io_bus_if.unit          bus,
   output logic            baud_sel,
   output logic            data_taken,   // Clears da and ovr in the UART
   output logic            int_rx_n,
   output logic            int_tx_n,
   output logic      [1:0] io_led        // 0 red, 1 green
);

   logic [2:0] ctrl;
   logic       rx_irq;
   logic       tx_irq;
   logic       ovr;

   // Control register, enables and baud select
   always_ff @(posedge sysclk) begin
      if (rst) begin
         ctrl <= 3'b000;
      end else if (bus.cmd == io_pkg::CMD_WR_CTRL) begin
         ctrl <= bus.wdata[2:0];
      end
   end

   always_comb begin
      if (bus.cmd == io_pkg::CMD_RD_CTRL) begin
         bus.rdata_reg = {13'd0, ctrl};
      end else begin
         bus.rdata_reg = 16'h0000;
      end
   end

   assign baud_sel = ctrl[io_pkg::CTRL_BAUD_SEL];

   // Reading the data register consumes the byte
   assign data_taken = (bus.cmd == io_pkg::CMD_RD_DATA);

   // Interrupt sources
   assign rx_irq = bus.status[io_pkg::STAT_DA] & ctrl[io_pkg::CTRL_RX_IE];
   assign tx_irq = bus.status[io_pkg::STAT_TBMT] & ctrl[io_pkg::CTRL_TX_IE];

   // Lines follow their condition one cycle late
   always_ff @(posedge sysclk) begin
      if (rst) begin
         int_rx_n <= 1'b1;
         int_tx_n <= 1'b1;
      end else begin
         int_rx_n <= ~rx_irq;
         int_tx_n <= ~tx_irq;
      end
   end

   assign ovr = bus.status[io_pkg::STAT_OVR];

   // Red on overrun, otherwise green
   assign io_led[0] = ovr;
   assign io_led[1] = ~ovr;

endmodule

`default_nettype wire

// File: verilog/io_dcd.sv
`default_nettype none

module io_dcd (
   input  wire logic        sysclk,
   input  wire logic        rst,
   input  wire logic [4:0]  cs_io,     // Microcode I/O field
   input  wire logic [7:0]  idb_in,
   output logic      [15:0] idb_out,
   io_bus_if.decoder        bus
);

   io_pkg::io_cmd_e cmd_next;
   logic            rd_cmd;
   logic [15:0]     rdata_or;

   // Field to command, anything unknown is a no-op
   always_comb begin
      case (cs_io)
         io_pkg::CODE_RD_DATA:   cmd_next = io_pkg::CMD_RD_DATA;
         io_pkg::CODE_WR_DATA:   cmd_next = io_pkg::CMD_WR_DATA;
         io_pkg::CODE_RD_STATUS: cmd_next = io_pkg::CMD_RD_STATUS;
         io_pkg::CODE_RD_CTRL:   cmd_next = io_pkg::CMD_RD_CTRL;
         io_pkg::CODE_WR_CTRL:   cmd_next = io_pkg::CMD_WR_CTRL;
         default:                cmd_next = io_pkg::CMD_NONE;
      endcase
   end

   // Command valid for exactly one cycle
   always_ff @(posedge sysclk) begin
      if (rst) begin
         bus.cmd <= io_pkg::CMD_NONE;
      end else begin
         bus.cmd <= cmd_next;
      end
   end

   always_ff @(posedge sysclk) begin
      bus.wdata <= idb_in;   // Taken with the command
   end

   always_comb begin
      case (bus.cmd)
         io_pkg::CMD_RD_DATA,
         io_pkg::CMD_RD_STATUS,
         io_pkg::CMD_RD_CTRL: rd_cmd = 1'b1;
         default:             rd_cmd = 1'b0;
      endcase
   end

   // Wired-OR of the unit read lines
   assign rdata_or = bus.rdata_uart | bus.rdata_reg;

   // Held until the next read
   always_ff @(posedge sysclk) begin
      if (rst) begin
         idb_out <= 16'h0000;
      end else if (rd_cmd) begin
         idb_out <= rdata_or;
      end
   end

endmodule

`default_nettype wire

// File: verilog/io_bus_if.sv
`default_nettype none

// Internal I/O bus, decoder to units
interface io_bus_if;

   io_pkg::io_cmd_e cmd;          // One cycle per command
   logic [7:0]      wdata;
   logic [15:0]     rdata_uart;   // Zero unless UART read
   logic [15:0]     rdata_reg;    // Zero unless control read
   logic [2:0]      status;       // From UART, see STAT_* bits

   modport decoder (
      output cmd,
      output wdata,
      input  rdata_uart,
      input  rdata_reg
   );

   // Each unit drives only its own read lines
   modport unit (
      input  cmd,
      input  wdata,
      output rdata_uart,
      output rdata_reg,
      output status
   );

endinterface

`default_nettype wire

// File: verilog/io_pkg.sv
`default_nettype none

package io_pkg;

   // Bus commands, one per cycle from the decoder
   typedef enum logic [2:0] {
      CMD_NONE      = 3'd0,
      CMD_RD_DATA   = 3'd1,
      CMD_WR_DATA   = 3'd2,
      CMD_RD_STATUS = 3'd3,
      CMD_RD_CTRL   = 3'd4,
      CMD_WR_CTRL   = 3'd5
   } io_cmd_e;

   // Microcode I/O field codes
   localparam logic [4:0] CODE_RD_DATA   = 5'h04;
   localparam logic [4:0] CODE_WR_DATA   = 5'h05;
   localparam logic [4:0] CODE_RD_STATUS = 5'h06;
   localparam logic [4:0] CODE_RD_CTRL   = 5'h07;
   localparam logic [4:0] CODE_WR_CTRL   = 5'h08;

   typedef enum logic [1:0] {
      TX_IDLE  = 2'd0,
      TX_START = 2'd1,
      TX_DATA  = 2'd2,
      TX_STOP  = 2'd3
   } tx_state_e;

   typedef enum logic [1:0] {
      RX_IDLE  = 2'd0,
      RX_START = 2'd1,
      RX_DATA  = 2'd2,
      RX_STOP  = 2'd3
   } rx_state_e;

   // Control register bits
   localparam int CTRL_RX_IE    = 0;
   localparam int CTRL_TX_IE    = 1;
   localparam int CTRL_BAUD_SEL = 2;

   // Status bits
   localparam int STAT_DA   = 0;   // Data available
   localparam int STAT_TBMT = 1;   // Transmit buffer empty
   localparam int STAT_OVR  = 2;   // Overrun

   // Clocks per bit
   localparam int DIV_FAST = 16;
   localparam int DIV_SLOW = 32;

   localparam int CNT_W = $clog2(DIV_SLOW);
   typedef logic [CNT_W-1:0] cnt_t;   // Bit timer

endpackage

`default_nettype wire
